// ==== verilog/spi_pkg.sv ====
package spi_pkg;

    // register byte addresses
    localparam logic [7:0] ADDR_SPMODE  = 8'h00;
    localparam logic [7:0] ADDR_SPIE    = 8'h04;
    localparam logic [7:0] ADDR_SPIM    = 8'h08;
    localparam logic [7:0] ADDR_SPCOM   = 8'h0C;
    localparam logic [7:0] ADDR_SPITF   = 8'h10;
    localparam logic [7:0] ADDR_SPIRF   = 8'h14;
    localparam logic [7:0] ADDR_CSMODE0 = 8'h20;  // CSMODEn at +4*n

    localparam int SPMODE_EN = 31;  // enable bit

    // writable bits per register
    localparam logic [31:0] SPMODE_WMASK = 32'h8000_0000;
    localparam logic [31:0] SPIE_MASK    = 32'h0000_C300;
    localparam logic [31:0] SPCOM_WMASK  = 32'hC000_FFFF;
    localparam logic [31:0] CSMODE_WMASK = 32'hEF00_FFF8;

    typedef logic [7:0] char_t;

    typedef struct packed {
        logic       cpol;
        logic       cpha;
        logic       cs_pol;   // 1 means active high
        logic       rsv0;
        logic [3:0] pm;       // half period is pm+1 clocks
        logic [7:0] rsv1;
        logic [3:0] csbef;
        logic [3:0] csaft;
        logic [4:0] cscg;
        logic [2:0] rsv2;
    } csmode_t;

    typedef struct packed {
        logic [1:0]  cs;
        logic [13:0] rsv;
        logic [15:0] tranlen;  // chars minus one
    } spcom_t;

    typedef struct packed {
        logic [15:0] rsv0;
        logic        txe;
        logic        don;   // sticky, write 1 to clear
        logic [3:0]  rsv1;
        logic        rne;
        logic        tnf;
        logic [7:0]  rsv2;
    } spie_t;

    typedef struct packed {
        logic [1:0]  cs;
        logic [15:0] tranlen;
        csmode_t     mode;
    } frame_cmd_t;

    localparam csmode_t     CSMODE_DEF = '0;
    localparam logic [31:0] SPMODE_DEF = '0;
    localparam logic [31:0] SPIM_DEF   = '0;
    localparam spcom_t      SPCOM_DEF  = '0;

endpackage

// ==== verilog/spi_char_fifo.sv ====
module spi_char_fifo #(
    parameter int DEPTH = 8
) (
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    input  logic           i_push,
    input  spi_pkg::char_t i_data,
    input  logic           i_pop,
    output spi_pkg::char_t o_data,
    output logic           o_full,
    output logic           o_empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    spi_pkg::char_t mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;
    logic           do_push;
    logic           do_pop;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;  // wrap for any depth
    endfunction

    assign o_full  = (count == (AW + 1)'(DEPTH));
    assign o_empty = (count == '0);
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
            count <= count + (AW + 1)'(do_push) - (AW + 1)'(do_pop);
        end
    end

    // a push into a full buffer would overwrite the head
    a_no_push_full: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        (i_push && o_full && !i_pop) |=> (o_full && (o_data == $past(o_data))));

endmodule

// ==== verilog/spi_brg.sv ====
module spi_brg (
    input  logic       S_SYSCLK,
    input  logic       S_RESETN,
    input  logic       i_run,
    input  logic [3:0] i_pm,
    input  logic       i_cpol,
    output logic       o_sck,
    output logic       o_lead,
    output logic       o_trail
);

    logic [3:0] cnt;
    logic       tick;

    // strobes mark the clock edge on which sck toggles
    assign tick    = i_run && (cnt == i_pm);
    assign o_lead  = tick && (o_sck == i_cpol);  // leaving idle level
    assign o_trail = tick && (o_sck != i_cpol);

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            cnt   <= '0;
            o_sck <= 1'b0;
        end else if (!i_run) begin
            cnt   <= '0;
            o_sck <= i_cpol;  // park at idle level
        end else if (tick) begin
            cnt   <= '0;
            o_sck <= ~o_sck;
        end else begin
            cnt <= cnt + 4'd1;
        end
    end

endmodule

// ==== verilog/spi_regs.sv ====
module spi_regs #(
    parameter int NCS = 4
) (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic [7:0]          i_awaddr,
    input  logic [31:0]         i_wdata,
    input  logic [3:0]          i_wstrb,
    input  logic                i_reg_wen,
    input  logic [7:0]          i_araddr,
    output logic [31:0]         o_rdata,
    input  logic                i_reg_rden,
    output logic                o_interrupt,
    input  logic                i_busy,
    input  logic                i_done,
    input  logic                i_tx_full,
    input  logic                i_tx_empty,
    input  spi_pkg::char_t      i_rx_head,
    input  logic                i_rx_empty,
    output logic                o_tx_push,
    output spi_pkg::char_t      o_tx_data,
    output logic                o_rx_pop,
    output logic                o_start,
    output spi_pkg::frame_cmd_t o_cmd,
    output logic [NCS-1:0]      o_cs_pol
);

    logic [31:0]      spmode;
    logic [31:0]      spim;
    spi_pkg::spcom_t  spcom;
    spi_pkg::csmode_t csmode [NCS];
    logic             don;
    spi_pkg::spie_t   spie;
    spi_pkg::spie_t   wr_spie;
    logic             wr_ok;
    logic             en;

    assign wr_ok   = i_reg_wen && (i_wstrb == 4'hf);  // full words only
    assign en      = spmode[spi_pkg::SPMODE_EN];
    assign wr_spie = i_wdata;

    // live status plus the sticky done flag
    always_comb begin
        spie     = '0;
        spie.txe = i_tx_empty;
        spie.don = don;
        spie.rne = !i_rx_empty;
        spie.tnf = !i_tx_full;
    end

    assign o_interrupt = |(32'(spie) & spim);

    assign o_tx_push = wr_ok && (i_awaddr == spi_pkg::ADDR_SPITF) && en && !i_tx_full;
    assign o_tx_data = i_wdata[7:0];
    assign o_rx_pop  = i_reg_rden && (i_araddr == spi_pkg::ADDR_SPIRF) && !i_rx_empty;

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            spmode  <= spi_pkg::SPMODE_DEF;
            spim    <= spi_pkg::SPIM_DEF;
            spcom   <= spi_pkg::SPCOM_DEF;
            don     <= 1'b0;
            o_start <= 1'b0;
            for (int k = 0; k < NCS; k++) begin
                csmode[k] <= spi_pkg::CSMODE_DEF;
            end
        end else begin
            o_start <= 1'b0;
            if (wr_ok) begin
                case (i_awaddr)
                    spi_pkg::ADDR_SPMODE: spmode <= i_wdata & spi_pkg::SPMODE_WMASK;
                    spi_pkg::ADDR_SPIE: begin
                        if (wr_spie.don) begin
                            don <= 1'b0;
                        end
                    end
                    spi_pkg::ADDR_SPIM: spim <= i_wdata & spi_pkg::SPIE_MASK;
                    spi_pkg::ADDR_SPCOM: begin
                        spcom   <= spi_pkg::spcom_t'(i_wdata & spi_pkg::SPCOM_WMASK);
                        o_start <= en && !i_busy && !o_start;  // ignored mid frame
                    end
                    default: ;
                endcase
                for (int k = 0; k < NCS; k++) begin
                    if (i_awaddr == spi_pkg::ADDR_CSMODE0 + 8'(4 * k)) begin
                        csmode[k] <= spi_pkg::csmode_t'(i_wdata & spi_pkg::CSMODE_WMASK);
                    end
                end
            end
            if (i_done) begin
                don <= 1'b1;  // set beats clear
            end
        end
    end

    always_comb begin
        o_rdata = '0;
        case (i_araddr)
            spi_pkg::ADDR_SPMODE: o_rdata = spmode;
            spi_pkg::ADDR_SPIE:   o_rdata = spie;
            spi_pkg::ADDR_SPIM:   o_rdata = spim;
            spi_pkg::ADDR_SPCOM:  o_rdata = spcom;
            spi_pkg::ADDR_SPIRF:  o_rdata = i_rx_empty ? 32'h0 : {24'h0, i_rx_head};
            default: ;
        endcase
        for (int k = 0; k < NCS; k++) begin
            if (i_araddr == spi_pkg::ADDR_CSMODE0 + 8'(4 * k)) begin
                o_rdata = csmode[k];
            end
        end
    end

    // mode of the addressed chip select
    always_comb begin
        o_cmd.cs      = spcom.cs;
        o_cmd.tranlen = spcom.tranlen;
        o_cmd.mode    = spi_pkg::CSMODE_DEF;
        for (int k = 0; k < NCS; k++) begin
            if (spcom.cs == 2'(k)) begin
                o_cmd.mode = csmode[k];
            end
            o_cs_pol[k] = csmode[k].cs_pol;
        end
    end

    a_start_idle: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        $rose(o_start) |-> !i_busy);

endmodule

// ==== verilog/spi_frame_ctrl.sv ====
module spi_frame_ctrl #(
    parameter int NCS = 4
) (
    input  logic                S_SYSCLK,
    input  logic                S_RESETN,
    input  logic                i_start,
    input  spi_pkg::frame_cmd_t i_cmd,
    input  logic [NCS-1:0]      i_cs_pol,
    input  spi_pkg::char_t      i_tx_data,
    input  logic                i_tx_empty,
    output logic                o_tx_pop,
    output logic                o_rx_push,
    output spi_pkg::char_t      o_rx_data,
    output logic                o_busy,
    output logic                o_done,
    output logic                o_spi_sck,
    output logic                o_spi_mosi,
    output logic [NCS-1:0]      o_spi_sel,
    input  logic                i_spi_miso
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_BEF, ST_DWAIT, ST_XFER, ST_AFT, ST_GAP
    } state_t;

    state_t           state;
    spi_pkg::csmode_t mode;
    logic [8:0]       dly;       // delay left in clocks
    logic [4:0]       hlen;      // clocks per half period
    logic [15:0]      char_cnt;
    logic [2:0]       bit_cnt;
    spi_pkg::char_t   tx_sr;
    spi_pkg::char_t   rx_sr;
    logic             sel_act;
    logic             run;
    logic             lead;
    logic             trail;
    logic             sample;
    logic             shift;
    logic             char_end;
    logic             last_char;

    assign mode      = i_cmd.mode;
    assign hlen      = {1'b0, mode.pm} + 5'd1;
    assign run       = (state == ST_XFER);
    assign sample    = mode.cpha ? trail : lead;
    assign shift     = mode.cpha ? lead : trail;
    assign char_end  = trail && (bit_cnt == 3'd7);  // 16th half period
    assign last_char = (char_cnt == i_cmd.tranlen);
    assign o_busy    = (state != ST_IDLE);
    assign o_rx_data = rx_sr;

    // next char starts right after the previous one when data is there
    assign o_tx_pop = !i_tx_empty && ((state == ST_DWAIT) || (char_end && !last_char));

    spi_brg u_brg (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_run    (run),
        .i_pm     (mode.pm),
        .i_cpol   (mode.cpol),
        .o_sck    (o_spi_sck),
        .o_lead   (lead),
        .o_trail  (trail)
    );

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state    <= ST_IDLE;
            dly      <= '0;
            char_cnt <= '0;
            bit_cnt  <= '0;
            sel_act  <= 1'b0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_start) begin
                        state    <= ST_BEF;
                        sel_act  <= 1'b1;
                        dly      <= 9'(mode.csbef) * 9'(hlen);
                        char_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                ST_BEF: begin
                    if (dly == '0) begin
                        state <= ST_DWAIT;
                    end else begin
                        dly <= dly - 9'd1;
                    end
                end
                ST_DWAIT: begin
                    if (o_tx_pop) begin
                        state <= ST_XFER;
                    end
                end
                ST_XFER: begin
                    if (trail) begin
                        bit_cnt <= bit_cnt + 3'd1;  // wraps at char end
                    end
                    if (char_end) begin
                        char_cnt <= char_cnt + 16'd1;
                        if (last_char) begin
                            state <= ST_AFT;
                            dly   <= 9'(mode.csaft) * 9'(hlen);
                        end else if (i_tx_empty) begin
                            state <= ST_DWAIT;
                        end
                    end
                end
                ST_AFT: begin
                    if (dly == '0) begin
                        state   <= ST_GAP;
                        sel_act <= 1'b0;
                        o_done  <= 1'b1;
                        dly     <= 9'(mode.cscg) * 9'(hlen);
                    end else begin
                        dly <= dly - 9'd1;
                    end
                end
                ST_GAP: begin
                    if (dly == '0) begin
                        state <= ST_IDLE;
                    end else begin
                        dly <= dly - 9'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // msb first and cpha 0 puts the first bit out at load time
    always_ff @(posedge S_SYSCLK) begin
        if (o_tx_pop) begin
            tx_sr <= mode.cpha ? i_tx_data : {i_tx_data[6:0], 1'b0};
        end else if (shift) begin
            tx_sr <= {tx_sr[6:0], 1'b0};
        end
        if (sample) begin
            rx_sr <= {rx_sr[6:0], i_spi_miso};
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            o_spi_mosi <= 1'b0;
            o_rx_push  <= 1'b0;
        end else begin
            o_rx_push <= char_end;  // rx_sr complete one clock later
            if (o_tx_pop) begin
                if (!mode.cpha) begin
                    o_spi_mosi <= i_tx_data[7];
                end
            end else if (shift) begin
                o_spi_mosi <= tx_sr[7];
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NCS; k++) begin
            if (sel_act && (i_cmd.cs == 2'(k))) begin
                o_spi_sel[k] = i_cs_pol[k];
            end else begin
                o_spi_sel[k] = ~i_cs_pol[k];  // idle level per line
            end
        end
    end

    // every popped byte begins a character at bit 0
    a_pop_starts_char: assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        o_tx_pop |=> ((state == ST_XFER) && (bit_cnt == 3'd0)));

endmodule

// ==== verilog/spi_master_top.sv ====
module spi_master_top #(
    parameter int NCS      = 4,
    parameter int TX_DEPTH = 8,
    parameter int RX_DEPTH = 8
) (
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    input  logic [7:0]     i_awaddr,
    input  logic [31:0]    i_wdata,
    input  logic [3:0]     i_wstrb,
    input  logic           i_reg_wen,
    input  logic [7:0]     i_araddr,
    output logic [31:0]    o_rdata,
    input  logic           i_reg_rden,
    output logic           o_interrupt,
    output logic           o_spi_sck,
    input  logic           i_spi_miso,
    output logic           o_spi_mosi,
    output logic [NCS-1:0] o_spi_sel
);

    logic                tx_push;
    spi_pkg::char_t      tx_data;
    logic                tx_pop;
    spi_pkg::char_t      tx_head;
    logic                tx_full;
    logic                tx_empty;
    logic                rx_push;
    spi_pkg::char_t      rx_data;
    logic                rx_pop;
    spi_pkg::char_t      rx_head;
    logic                rx_empty;
    logic                start;
    spi_pkg::frame_cmd_t cmd;
    logic [NCS-1:0]      cs_pol;
    logic                busy;
    logic                done;

    spi_regs #(.NCS(NCS)) u_regs (
        .S_SYSCLK    (S_SYSCLK),
        .S_RESETN    (S_RESETN),
        .i_awaddr    (i_awaddr),
        .i_wdata     (i_wdata),
        .i_wstrb     (i_wstrb),
        .i_reg_wen   (i_reg_wen),
        .i_araddr    (i_araddr),
        .o_rdata     (o_rdata),
        .i_reg_rden  (i_reg_rden),
        .o_interrupt (o_interrupt),
        .i_busy      (busy),
        .i_done      (done),
        .i_tx_full   (tx_full),
        .i_tx_empty  (tx_empty),
        .i_rx_head   (rx_head),
        .i_rx_empty  (rx_empty),
        .o_tx_push   (tx_push),
        .o_tx_data   (tx_data),
        .o_rx_pop    (rx_pop),
        .o_start     (start),
        .o_cmd       (cmd),
        .o_cs_pol    (cs_pol)
    );

    spi_char_fifo #(.DEPTH(TX_DEPTH)) u_tx_fifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_push   (tx_push),
        .i_data   (tx_data),
        .i_pop    (tx_pop),
        .o_data   (tx_head),
        .o_full   (tx_full),
        .o_empty  (tx_empty)
    );

    // rx overflow drops the byte inside the fifo
    spi_char_fifo #(.DEPTH(RX_DEPTH)) u_rx_fifo (
        .S_SYSCLK (S_SYSCLK),
        .S_RESETN (S_RESETN),
        .i_push   (rx_push),
        .i_data   (rx_data),
        .i_pop    (rx_pop),
        .o_data   (rx_head),
        .o_full   (),
        .o_empty  (rx_empty)
    );

    spi_frame_ctrl #(.NCS(NCS)) u_frame (
        .S_SYSCLK   (S_SYSCLK),
        .S_RESETN   (S_RESETN),
        .i_start    (start),
        .i_cmd      (cmd),
        .i_cs_pol   (cs_pol),
        .i_tx_data  (tx_head),
        .i_tx_empty (tx_empty),
        .o_tx_pop   (tx_pop),
        .o_rx_push  (rx_push),
        .o_rx_data  (rx_data),
        .o_busy     (busy),
        .o_done     (done),
        .o_spi_sck  (o_spi_sck),
        .o_spi_mosi (o_spi_mosi),
        .o_spi_sel  (o_spi_sel),
        .i_spi_miso (i_spi_miso)
    );

endmodule

// ==== test/spi_slave_model.sv ====
module spi_slave_model #(
    parameter int NCS = 4
) (
    input  logic           i_sck,
    input  logic           i_mosi,
    input  logic [NCS-1:0] i_sel,
    output logic           o_miso
);
    timeunit 1ns;
    timeprecision 1ps;

    logic           cpol;
    logic           cpha;
    logic           cs_pol;   // 1 means active high
    int             cs_idx;
    logic           act;
    spi_pkg::char_t miso_q [$];
    spi_pkg::char_t mosi_log [$];
    spi_pkg::char_t miso_sr;
    spi_pkg::char_t mosi_sr;
    int             miso_left;
    int             rx_cnt;

    assign act = (i_sel[cs_idx] === cs_pol);

    initial begin
        cpol      = 1'b0;
        cpha      = 1'b0;
        cs_pol    = 1'b0;
        cs_idx    = 0;
        o_miso    = 1'b0;
        miso_sr   = '0;
        mosi_sr   = '0;
        miso_left = 0;
        rx_cnt    = 0;
    end

    task automatic configure(input logic pol, input logic pha, input int idx,
                             input logic sel_pol);
        cpol   = pol;
        cpha   = pha;
        cs_idx = idx;
        cs_pol = sel_pol;
    endtask

    task automatic clear();
        miso_q.delete();
        mosi_log.delete();
    endtask

    task automatic add_miso(input spi_pkg::char_t b);
        miso_q.push_back(b);
    endtask

    function automatic int got_count();
        return mosi_log.size();
    endfunction

    function automatic spi_pkg::char_t got_byte(input int idx);
        if (idx < mosi_log.size()) begin
            return mosi_log[idx];
        end
        return '0;
    endfunction

    // next miso bit, msb first, zero once the queue runs dry
    task automatic present_bit();
        if (miso_left == 0) begin
            miso_sr   = (miso_q.size() > 0) ? miso_q.pop_front() : 8'h00;
            miso_left = 8;
        end
        o_miso    = miso_sr[7];
        miso_sr   = {miso_sr[6:0], 1'b0};
        miso_left = miso_left - 1;
    endtask

    task automatic take_bit();
        mosi_sr = {mosi_sr[6:0], i_mosi};
        rx_cnt  = rx_cnt + 1;
        if (rx_cnt == 8) begin
            mosi_log.push_back(mosi_sr);
            rx_cnt = 0;
        end
    endtask

    always @(act) begin
        if (act === 1'b1) begin
            miso_left = 0;
            rx_cnt    = 0;
            if (!cpha) begin
                present_bit();  // first bit before the first edge
            end
        end
    end

    always @(i_sck) begin
        if (act === 1'b1 && (i_sck === 1'b0 || i_sck === 1'b1)) begin
            if (i_sck != cpol) begin  // leading edge
                if (cpha) begin
                    present_bit();
                end else begin
                    take_bit();
                end
            end else begin
                if (cpha) begin
                    take_bit();
                end else begin
                    present_bit();
                end
            end
        end
    end

endmodule

// ==== test/tb_spi_master.sv ====
module tb_spi_master;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NCS           = 4;
    localparam int          FRAME_TIMEOUT = 4000;  // clock cycles
    localparam logic [31:0] MODE_EN       = 32'h8000_0000;
    localparam logic [31:0] SPIE_DON      = 32'h0000_4000;

    logic           S_SYSCLK;
    logic           S_RESETN;
    logic [7:0]     awaddr;
    logic [31:0]    wdata;
    logic [3:0]     wstrb;
    logic           reg_wen;
    logic [7:0]     araddr;
    logic [31:0]    rdata;
    logic           reg_rden;
    logic           interrupt;
    logic           spi_sck;
    logic           spi_miso;
    logic           spi_mosi;
    logic [NCS-1:0] spi_sel;

    int             errors;
    int             checks;
    spi_pkg::char_t tx_exp [$];
    spi_pkg::char_t rx_exp [$];

    spi_master_top #(.NCS(NCS), .TX_DEPTH(8), .RX_DEPTH(8)) i_dut (
        .S_SYSCLK    (S_SYSCLK),
        .S_RESETN    (S_RESETN),
        .i_awaddr    (awaddr),
        .i_wdata     (wdata),
        .i_wstrb     (wstrb),
        .i_reg_wen   (reg_wen),
        .i_araddr    (araddr),
        .o_rdata     (rdata),
        .i_reg_rden  (reg_rden),
        .o_interrupt (interrupt),
        .o_spi_sck   (spi_sck),
        .i_spi_miso  (spi_miso),
        .o_spi_mosi  (spi_mosi),
        .o_spi_sel   (spi_sel)
    );

    spi_slave_model #(.NCS(NCS)) u_slave (
        .i_sck  (spi_sck),
        .i_mosi (spi_mosi),
        .i_sel  (spi_sel),
        .o_miso (spi_miso)
    );

    initial begin
        S_SYSCLK = 1'b0;
        forever #10 S_SYSCLK = ~S_SYSCLK;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] spcom_val(input logic [1:0] cs, input logic [15:0] len);
        return {cs, 14'h0, len};
    endfunction

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge S_SYSCLK);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        reg_wen = 1'b1;
        @(negedge S_SYSCLK);
        reg_wen = 1'b0;
    endtask

    // rden also pops SPIRF on the edge in between
    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge S_SYSCLK);
        araddr   = addr;
        reg_rden = 1'b1;
        #5;
        data = rdata;
        @(negedge S_SYSCLK);
        reg_rden = 1'b0;
    endtask

    task automatic wait_done(input string name, output logic [NCS-1:0] sel_and);
        int          n;
        logic [31:0] v;
        sel_and = '1;
        n       = 0;
        v       = '0;
        while (!v[14] && n < FRAME_TIMEOUT) begin
            @(negedge S_SYSCLK);
            araddr = spi_pkg::ADDR_SPIE;
            #5;
            v       = rdata;
            sel_and = sel_and & spi_sel;  // lines seen low stay 0
            n++;
        end
        if (!v[14]) begin
            errors++;
            $display("%s: timed out waiting for the end of the frame", name);
        end
    endtask

    // random tx bytes and the slave's answers queued before chip select
    task automatic prepare_bytes(input int n);
        spi_pkg::char_t b;
        tx_exp.delete();
        rx_exp.delete();
        u_slave.clear();
        for (int k = 0; k < n; k++) begin
            b = 8'($urandom);
            tx_exp.push_back(b);
            b = 8'($urandom);
            rx_exp.push_back(b);
            u_slave.add_miso(b);
        end
    endtask

    task automatic push_tx();
        foreach (tx_exp[k]) begin
            reg_write(spi_pkg::ADDR_SPITF, {24'h0, tx_exp[k]});
        end
    endtask

    task automatic finish_frame(input string name, input int n, input logic [NCS-1:0] sel_exp);
        logic [NCS-1:0] sel_and;
        logic [31:0]    v;
        wait_done(name, sel_and);
        check({name, " sel"}, sel_exp, sel_and);
        check({name, " count"}, n, u_slave.got_count());
        for (int k = 0; k < n; k++) begin
            check({name, " mosi"}, tx_exp[k], u_slave.got_byte(k));
        end
        for (int k = 0; k < n; k++) begin
            reg_read(spi_pkg::ADDR_SPIRF, v);
            check({name, " spirf"}, rx_exp[k], v);
        end
        reg_read(spi_pkg::ADDR_SPIE, v);
        check({name, " rne"}, 0, v[9]);
    endtask

    task automatic test_reset();
        logic [31:0] v;
        reg_read(spi_pkg::ADDR_SPMODE, v);
        check("reset spmode", 0, v);
        reg_read(spi_pkg::ADDR_SPIM, v);
        check("reset spim", 0, v);
        reg_read(spi_pkg::ADDR_SPCOM, v);
        check("reset spcom", 0, v);
        for (int k = 0; k < 4; k++) begin
            reg_read(spi_pkg::ADDR_CSMODE0 + 8'(4 * k), v);
            check("reset csmode", 0, v);
        end
        check("reset sel", 4'hf, spi_sel);
        check("reset sck", 0, spi_sck);
        check("reset irq", 0, interrupt);
    endtask

    task automatic test_mode0();
        u_slave.configure(1'b0, 1'b0, 0, 1'b0);
        reg_write(spi_pkg::ADDR_SPMODE, MODE_EN);
        prepare_bytes(4);
        push_tx();
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd0, 16'd3));
        finish_frame("mode0", 4, 4'b1110);
        reg_write(spi_pkg::ADDR_SPIE, SPIE_DON);
    endtask

    task automatic test_done_irq();
        logic [31:0] v;
        reg_write(spi_pkg::ADDR_SPIM, SPIE_DON);
        @(negedge S_SYSCLK);
        check("irq idle", 0, interrupt);
        prepare_bytes(1);
        push_tx();
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd0, 16'd0));
        finish_frame("irq frame", 1, 4'b1110);
        check("irq raised", 1, interrupt);
        reg_write(spi_pkg::ADDR_SPIE, SPIE_DON);
        reg_read(spi_pkg::ADDR_SPIE, v);
        check("irq don cleared", 0, v[14]);
        check("irq cleared", 0, interrupt);
        // same frame with the mask off
        reg_write(spi_pkg::ADDR_SPIM, 32'h0);
        prepare_bytes(1);
        push_tx();
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd0, 16'd0));
        finish_frame("irq masked frame", 1, 4'b1110);
        check("irq masked", 0, interrupt);
        reg_read(spi_pkg::ADDR_SPIE, v);
        check("irq masked don", 1, v[14]);
        reg_write(spi_pkg::ADDR_SPIE, SPIE_DON);
    endtask

    task automatic test_data_wait();
        int bad;
        prepare_bytes(2);
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd0, 16'd1));
        bad = 0;
        repeat (50) begin
            @(negedge S_SYSCLK);
            if (spi_sel[0] !== 1'b0 || spi_sck !== 1'b0) begin
                bad++;
            end
        end
        check("data wait idle", 0, bad);
        push_tx();
        finish_frame("data wait", 2, 4'b1110);
        reg_write(spi_pkg::ADDR_SPIE, SPIE_DON);
    endtask

    task automatic test_enable_limits();
        logic [31:0] v;
        int          started;
        reg_write(spi_pkg::ADDR_SPMODE, 32'h0);
        u_slave.clear();
        reg_write(spi_pkg::ADDR_SPITF, 32'h5a);
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd0, 16'd0));
        started = 0;
        for (int n = 0; n < 100; n++) begin
            @(negedge S_SYSCLK);
            araddr = spi_pkg::ADDR_SPIE;
            #5;
            if (rdata[14] || spi_sel[0] !== 1'b1) begin
                started++;
            end
        end
        check("disabled no frame", 0, started);
        reg_read(spi_pkg::ADDR_SPIE, v);
        check("disabled txe", 1, v[15]);
        check("disabled slave count", 0, u_slave.got_count());
        reg_write(spi_pkg::ADDR_SPMODE, MODE_EN);
        prepare_bytes(8);
        push_tx();
        reg_read(spi_pkg::ADDR_SPIE, v);
        check("fifo full tnf", 0, v[8]);
        reg_write(spi_pkg::ADDR_SPITF, 32'ha5);  // ninth byte is dropped
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd0, 16'd7));
        finish_frame("fifo limits", 8, 4'b1110);
        reg_read(spi_pkg::ADDR_SPIE, v);
        check("fifo limits txe", 1, v[15]);
        reg_write(spi_pkg::ADDR_SPIE, SPIE_DON);
    endtask

    task automatic test_cs_modes();
        logic [31:0] v;
        reg_write(spi_pkg::ADDR_CSMODE0 + 8'd8, 32'hC200_0000);  // cpol 1 cpha 1 pm 2
        reg_read(spi_pkg::ADDR_CSMODE0 + 8'd8, v);
        check("cs modes csmode2", 32'hC200_0000, v);
        u_slave.configure(1'b1, 1'b1, 2, 1'b0);
        prepare_bytes(2);
        // select cs 2 while disabled so sck parks high first
        reg_write(spi_pkg::ADDR_SPMODE, 32'h0);
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd2, 16'd1));
        @(negedge S_SYSCLK);
        check("cs modes sck before", 1, spi_sck);
        check("cs modes sel before", 4'hf, spi_sel);
        reg_write(spi_pkg::ADDR_SPMODE, MODE_EN);
        push_tx();
        reg_write(spi_pkg::ADDR_SPCOM, spcom_val(2'd2, 16'd1));
        finish_frame("cs modes", 2, 4'b1011);
        check("cs modes sck after", 1, spi_sck);
        check("cs modes sel after", 4'hf, spi_sel);
        reg_write(spi_pkg::ADDR_SPIE, SPIE_DON);
        reg_write(spi_pkg::ADDR_CSMODE0 + 8'd4, 32'h2000_0000);
        @(negedge S_SYSCLK);
        check("cs modes idle level", 4'b1101, spi_sel);
    endtask

    initial begin
        errors   = 0;
        checks   = 0;
        S_RESETN = 1'b0;
        awaddr   = '0;
        wdata    = '0;
        wstrb    = '0;
        reg_wen  = 1'b0;
        araddr   = '0;
        reg_rden = 1'b0;
        void'($urandom(66));
        repeat (10) @(negedge S_SYSCLK);
        S_RESETN = 1'b1;

        test_reset();
        test_mode0();
        test_done_irq();
        test_data_wait();
        test_enable_limits();
        test_cs_modes();  // last, leaves cs 2 in mode 3

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/spi_pkg.sv
verilog/spi_char_fifo.sv
verilog/spi_brg.sv
verilog/spi_regs.sv
verilog/spi_frame_ctrl.sv
verilog/spi_master_top.sv
test/spi_slave_model.sv
test/tb_spi_master.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - files:
      - verilog/spi_pkg.sv
      - verilog/spi_char_fifo.sv
      - verilog/spi_brg.sv
      - verilog/spi_regs.sv
      - verilog/spi_frame_ctrl.sv
      - verilog/spi_master_top.sv
  - target: test
    files:
      - test/spi_slave_model.sv
      - test/tb_spi_master.sv
